// ==== rtl/llc_pkg.sv ====
// LLC channel front end definitions
// Field widths and flattened payload widths of the request and response channels

`default_nettype none

package llc_pkg;

    // Message fields
    localparam int COH_MSG_BITS     = 3;
    localparam int HPROT_BITS       = 2;
    localparam int LINE_ADDR_BITS   = 26;
    localparam int LINE_BITS        = 32;
    localparam int REQ_ID_BITS      = 4;
    localparam int DEST_ID_BITS     = 4;
    localparam int WORD_OFFSET_BITS = 2;
    localparam int VALID_WORDS_BITS = 2;
    localparam int INVACK_CNT_BITS  = 4;

    // Request input word
    // {coh_msg, hprot, addr, line, req_id, word_offset, valid_words}
    localparam int REQ_IN_BITS = COH_MSG_BITS + HPROT_BITS + LINE_ADDR_BITS + LINE_BITS
                               + REQ_ID_BITS + WORD_OFFSET_BITS + VALID_WORDS_BITS;

    // Position of the address inside a request word
    localparam int REQ_IN_ADDR_LSB = LINE_BITS + REQ_ID_BITS + WORD_OFFSET_BITS
                                   + VALID_WORDS_BITS;

    // Response input word
    // {coh_msg, addr, line, req_id}
    localparam int RSP_IN_BITS = COH_MSG_BITS + LINE_ADDR_BITS + LINE_BITS + REQ_ID_BITS;

    // Response output word
    // {coh_msg, addr, line, invack_cnt, req_id, dest_id, word_offset}
    localparam int RSP_OUT_BITS = COH_MSG_BITS + LINE_ADDR_BITS + LINE_BITS
                                + INVACK_CNT_BITS + REQ_ID_BITS + DEST_ID_BITS
                                + WORD_OFFSET_BITS;

endpackage

`default_nettype wire

// ==== rtl/llc_bypass_buffer.sv ====
// One-entry bypassable skid buffer
// Passes a word through when downstream is ready, parks it otherwise

`default_nettype none

module llc_bypass_buffer
    import llc_pkg::*;
#(
    parameter int WIDTH = RSP_OUT_BITS
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             up_valid_i,
    output logic             up_ready_o,
    input  logic [WIDTH-1:0] up_data_i,
    output logic             down_valid_o,
    input  logic             down_ready_i,
    output logic [WIDTH-1:0] down_data_o
);

    logic             held;
    logic [WIDTH-1:0] hold_data;
    logic             park;

    // Upstream word accepted but not taken downstream
    assign park = up_valid_i && !held && !down_ready_i;

    // Only the holding register decides upstream ready
    assign up_ready_o = !held;

    assign down_valid_o = up_valid_i || held;
    assign down_data_o  = held ? hold_data : up_data_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            held <= 1'b0;
        end else if (held) begin
            if (down_ready_i) begin
                held <= 1'b0;
            end
        end else if (park) begin
            held <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hold_data <= '0;
        end else if (park) begin
            hold_data <= up_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/llc_input_channel.sv ====
// LLC input channel
// Skid buffer plus capture register facing the cache controller

`default_nettype none

module llc_input_channel
    import llc_pkg::*;
#(
    parameter int WIDTH = RSP_IN_BITS
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_i,
    output logic             ready_o,
    input  logic [WIDTH-1:0] data_i,
    output logic             valid_int_o,
    input  logic             ready_int_i,
    output logic [WIDTH-1:0] data_o
);

    logic [WIDTH-1:0] buf_data;
    logic [WIDTH-1:0] capture;

    llc_bypass_buffer #(
        .WIDTH(WIDTH)
    ) buf_i (
        .clk         (clk),
        .rst         (rst),
        .up_valid_i  (valid_i),
        .up_ready_o  (ready_o),
        .up_data_i   (data_i),
        .down_valid_o(valid_int_o),
        .down_ready_i(ready_int_i),
        .down_data_o (buf_data)
    );

    // Controller sees the word the cycle after it takes it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            capture <= '0;
        end else if (valid_int_o && ready_int_i) begin
            capture <= buf_data;
        end
    end

    assign data_o = capture;

endmodule

`default_nettype wire

// ==== rtl/llc_req_in_channel.sv ====
// LLC request input channel
// Skid buffer, capture register and a stalled copy the controller can replay

`default_nettype none

module llc_req_in_channel
    import llc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid_i,
    output logic                   ready_o,
    input  logic [REQ_IN_BITS-1:0] data_i,
    output logic                   valid_int_o,
    input  logic                   ready_int_i,
    input  logic                   set_stalled_i,
    input  logic                   update_from_stalled_i,
    output logic [REQ_IN_BITS-1:0] data_o,
    output logic [REQ_IN_BITS-1:0] stalled_data_o
);

    logic [REQ_IN_BITS-1:0] buf_data;
    logic [REQ_IN_BITS-1:0] capture;
    logic [REQ_IN_BITS-1:0] stalled;

    llc_bypass_buffer #(
        .WIDTH(REQ_IN_BITS)
    ) buf_i (
        .clk         (clk),
        .rst         (rst),
        .up_valid_i  (valid_i),
        .up_ready_o  (ready_o),
        .up_data_i   (data_i),
        .down_valid_o(valid_int_o),
        .down_ready_i(ready_int_i),
        .down_data_o (buf_data)
    );

    // Replay wins over a fresh handshake
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            capture <= '0;
        end else if (update_from_stalled_i) begin
            capture <= stalled;
        end else if (valid_int_o && ready_int_i) begin
            capture <= buf_data;
        end
    end

    // Parked copy of the current request
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stalled <= '0;
        end else if (set_stalled_i) begin
            stalled <= capture;
        end
    end

    assign data_o         = capture;
    assign stalled_data_o = stalled;

endmodule

`default_nettype wire

// ==== rtl/llc_channels.sv ====
// LLC channel front end
// Request and response inputs toward the controller, response output toward the network

`default_nettype none

module llc_channels
    import llc_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    // Request input
    input  logic                        req_in_valid_i,
    output logic                        req_in_ready_o,
    input  logic [COH_MSG_BITS-1:0]     req_in_coh_msg_i,
    input  logic [HPROT_BITS-1:0]       req_in_hprot_i,
    input  logic [LINE_ADDR_BITS-1:0]   req_in_addr_i,
    input  logic [LINE_BITS-1:0]        req_in_line_i,
    input  logic [REQ_ID_BITS-1:0]      req_in_req_id_i,
    input  logic [WORD_OFFSET_BITS-1:0] req_in_word_offset_i,
    input  logic [VALID_WORDS_BITS-1:0] req_in_valid_words_i,
    output logic                        req_in_valid_int_o,
    input  logic                        req_in_ready_int_i,
    output logic [COH_MSG_BITS-1:0]     req_in_coh_msg_o,
    output logic [HPROT_BITS-1:0]       req_in_hprot_o,
    output logic [LINE_ADDR_BITS-1:0]   req_in_addr_o,
    output logic [LINE_BITS-1:0]        req_in_line_o,
    output logic [REQ_ID_BITS-1:0]      req_in_req_id_o,
    output logic [WORD_OFFSET_BITS-1:0] req_in_word_offset_o,
    output logic [VALID_WORDS_BITS-1:0] req_in_valid_words_o,
    // Stall and replay
    input  logic                        set_req_in_stalled_i,
    input  logic                        update_req_in_from_stalled_i,
    output logic [LINE_ADDR_BITS-1:0]   req_in_stalled_addr_o,
    // Response input
    input  logic                        rsp_in_valid_i,
    output logic                        rsp_in_ready_o,
    input  logic [COH_MSG_BITS-1:0]     rsp_in_coh_msg_i,
    input  logic [LINE_ADDR_BITS-1:0]   rsp_in_addr_i,
    input  logic [LINE_BITS-1:0]        rsp_in_line_i,
    input  logic [REQ_ID_BITS-1:0]      rsp_in_req_id_i,
    output logic                        rsp_in_valid_int_o,
    input  logic                        rsp_in_ready_int_i,
    output logic [COH_MSG_BITS-1:0]     rsp_in_coh_msg_o,
    output logic [LINE_ADDR_BITS-1:0]   rsp_in_addr_o,
    output logic [LINE_BITS-1:0]        rsp_in_line_o,
    output logic [REQ_ID_BITS-1:0]      rsp_in_req_id_o,
    // Response output
    input  logic                        rsp_out_valid_int_i,
    output logic                        rsp_out_ready_int_o,
    input  logic [COH_MSG_BITS-1:0]     rsp_out_coh_msg_i,
    input  logic [LINE_ADDR_BITS-1:0]   rsp_out_addr_i,
    input  logic [LINE_BITS-1:0]        rsp_out_line_i,
    input  logic [INVACK_CNT_BITS-1:0]  rsp_out_invack_cnt_i,
    input  logic [REQ_ID_BITS-1:0]      rsp_out_req_id_i,
    input  logic [DEST_ID_BITS-1:0]     rsp_out_dest_id_i,
    input  logic [WORD_OFFSET_BITS-1:0] rsp_out_word_offset_i,
    output logic                        rsp_out_valid_o,
    input  logic                        rsp_out_ready_i,
    output logic [COH_MSG_BITS-1:0]     rsp_out_coh_msg_o,
    output logic [LINE_ADDR_BITS-1:0]   rsp_out_addr_o,
    output logic [LINE_BITS-1:0]        rsp_out_line_o,
    output logic [INVACK_CNT_BITS-1:0]  rsp_out_invack_cnt_o,
    output logic [REQ_ID_BITS-1:0]      rsp_out_req_id_o,
    output logic [DEST_ID_BITS-1:0]     rsp_out_dest_id_o,
    output logic [WORD_OFFSET_BITS-1:0] rsp_out_word_offset_o
);

    logic [REQ_IN_BITS-1:0]  req_in_word;
    logic [REQ_IN_BITS-1:0]  req_in_cap;
    logic [REQ_IN_BITS-1:0]  req_in_stalled;
    logic [RSP_IN_BITS-1:0]  rsp_in_word;
    logic [RSP_IN_BITS-1:0]  rsp_in_cap;
    logic [RSP_OUT_BITS-1:0] rsp_out_word;
    logic [RSP_OUT_BITS-1:0] rsp_out_net;

    assign req_in_word = {req_in_coh_msg_i, req_in_hprot_i, req_in_addr_i, req_in_line_i,
                          req_in_req_id_i, req_in_word_offset_i, req_in_valid_words_i};

    llc_req_in_channel req_in_i (
        .clk                  (clk),
        .rst                  (rst),
        .valid_i              (req_in_valid_i),
        .ready_o              (req_in_ready_o),
        .data_i               (req_in_word),
        .valid_int_o          (req_in_valid_int_o),
        .ready_int_i          (req_in_ready_int_i),
        .set_stalled_i        (set_req_in_stalled_i),
        .update_from_stalled_i(update_req_in_from_stalled_i),
        .data_o               (req_in_cap),
        .stalled_data_o       (req_in_stalled)
    );

    assign {req_in_coh_msg_o, req_in_hprot_o, req_in_addr_o, req_in_line_o,
            req_in_req_id_o, req_in_word_offset_o, req_in_valid_words_o} = req_in_cap;

    // Only the address of the parked request leaves the block
    assign req_in_stalled_addr_o =
        req_in_stalled[REQ_IN_ADDR_LSB +: LINE_ADDR_BITS];

    assign rsp_in_word = {rsp_in_coh_msg_i, rsp_in_addr_i, rsp_in_line_i, rsp_in_req_id_i};

    llc_input_channel #(
        .WIDTH(RSP_IN_BITS)
    ) rsp_in_i (
        .clk        (clk),
        .rst        (rst),
        .valid_i    (rsp_in_valid_i),
        .ready_o    (rsp_in_ready_o),
        .data_i     (rsp_in_word),
        .valid_int_o(rsp_in_valid_int_o),
        .ready_int_i(rsp_in_ready_int_i),
        .data_o     (rsp_in_cap)
    );

    assign {rsp_in_coh_msg_o, rsp_in_addr_o, rsp_in_line_o, rsp_in_req_id_o} = rsp_in_cap;

    assign rsp_out_word = {rsp_out_coh_msg_i, rsp_out_addr_i, rsp_out_line_i,
                           rsp_out_invack_cnt_i, rsp_out_req_id_i, rsp_out_dest_id_i,
                           rsp_out_word_offset_i};

    // Controller is upstream here, network downstream
    llc_bypass_buffer #(
        .WIDTH(RSP_OUT_BITS)
    ) rsp_out_i (
        .clk         (clk),
        .rst         (rst),
        .up_valid_i  (rsp_out_valid_int_i),
        .up_ready_o  (rsp_out_ready_int_o),
        .up_data_i   (rsp_out_word),
        .down_valid_o(rsp_out_valid_o),
        .down_ready_i(rsp_out_ready_i),
        .down_data_o (rsp_out_net)
    );

    assign {rsp_out_coh_msg_o, rsp_out_addr_o, rsp_out_line_o, rsp_out_invack_cnt_o,
            rsp_out_req_id_o, rsp_out_dest_id_o, rsp_out_word_offset_o} = rsp_out_net;

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
// Testbench clock and reset
// 20-unit clock period, active-low reset held for 10 cycles

`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_o = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/llc_channels_asserts.sv ====
// LLC channel protocol checks
// Reset state, skid ready rule and response output stability

`default_nettype none

module llc_channels_asserts
    import llc_pkg::*;
(
    input logic                        clk,
    input logic                        rst,
    input logic                        req_in_valid_int_o,
    input logic                        req_in_ready_o,
    input logic                        rsp_in_valid_int_o,
    input logic                        rsp_in_ready_o,
    input logic                        rsp_out_valid_o,
    input logic                        rsp_out_ready_int_o,
    input logic                        rsp_out_ready_i,
    input logic [COH_MSG_BITS-1:0]     rsp_out_coh_msg_o,
    input logic [LINE_ADDR_BITS-1:0]   rsp_out_addr_o,
    input logic [LINE_BITS-1:0]        rsp_out_line_o,
    input logic [INVACK_CNT_BITS-1:0]  rsp_out_invack_cnt_o,
    input logic [REQ_ID_BITS-1:0]      rsp_out_req_id_o,
    input logic [DEST_ID_BITS-1:0]     rsp_out_dest_id_o,
    input logic [WORD_OFFSET_BITS-1:0] rsp_out_word_offset_o
);

    int unsigned             fail_count = 0;
    logic [RSP_OUT_BITS-1:0] rsp_out_fields;

    assign rsp_out_fields = {rsp_out_coh_msg_o, rsp_out_addr_o, rsp_out_line_o,
                             rsp_out_invack_cnt_o, rsp_out_req_id_o, rsp_out_dest_id_o,
                             rsp_out_word_offset_o};

    // Idle during reset and in the first cycle after it
    reset_state: assert property (@(posedge clk)
        (!rst || $rose(rst)) |-> (!req_in_valid_int_o && !rsp_in_valid_int_o
            && !rsp_out_valid_o && req_in_ready_o && rsp_in_ready_o && rsp_out_ready_int_o))
    else begin
        $error("Channel outputs not idle around reset");
        fail_count++;
    end

    // A full buffer always presents its word
    skid_rule: assert property (@(posedge clk) disable iff (!rst)
        (!req_in_ready_o -> req_in_valid_int_o) && (!rsp_in_ready_o -> rsp_in_valid_int_o)
        && (!rsp_out_ready_int_o -> rsp_out_valid_o))
    else begin
        $error("Input ready low with no word presented");
        fail_count++;
    end

    rsp_out_stable: assert property (@(posedge clk) disable iff (!rst)
        (rsp_out_valid_o && !rsp_out_ready_i) |=> (rsp_out_valid_o && $stable(rsp_out_fields)))
    else begin
        $error("Response output changed under back-pressure");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== tb/llc_channels_tb.sv ====
// LLC channel front end testbench
// Random traffic on all three channels checked against reference queues

`default_nettype none

module llc_channels_tb
    import llc_pkg::*;
();

    localparam int WORDS      = 300;
    localparam int MAX_CYCLES = 6000;

    logic clk;
    logic rst;
    logic req_in_valid_i, req_in_ready_o, req_in_valid_int_o, req_in_ready_int_i;
    logic set_req_in_stalled_i, update_req_in_from_stalled_i;
    logic rsp_in_valid_i, rsp_in_ready_o, rsp_in_valid_int_o, rsp_in_ready_int_i;
    logic rsp_out_valid_int_i, rsp_out_ready_int_o, rsp_out_valid_o, rsp_out_ready_i;
    logic [COH_MSG_BITS-1:0]     req_in_coh_msg_i, req_in_coh_msg_o;
    logic [HPROT_BITS-1:0]       req_in_hprot_i, req_in_hprot_o;
    logic [LINE_ADDR_BITS-1:0]   req_in_addr_i, req_in_addr_o, req_in_stalled_addr_o;
    logic [LINE_BITS-1:0]        req_in_line_i, req_in_line_o;
    logic [REQ_ID_BITS-1:0]      req_in_req_id_i, req_in_req_id_o;
    logic [WORD_OFFSET_BITS-1:0] req_in_word_offset_i, req_in_word_offset_o;
    logic [VALID_WORDS_BITS-1:0] req_in_valid_words_i, req_in_valid_words_o;
    logic [COH_MSG_BITS-1:0]     rsp_in_coh_msg_i, rsp_in_coh_msg_o;
    logic [LINE_ADDR_BITS-1:0]   rsp_in_addr_i, rsp_in_addr_o;
    logic [LINE_BITS-1:0]        rsp_in_line_i, rsp_in_line_o;
    logic [REQ_ID_BITS-1:0]      rsp_in_req_id_i, rsp_in_req_id_o;
    logic [COH_MSG_BITS-1:0]     rsp_out_coh_msg_i, rsp_out_coh_msg_o;
    logic [LINE_ADDR_BITS-1:0]   rsp_out_addr_i, rsp_out_addr_o;
    logic [LINE_BITS-1:0]        rsp_out_line_i, rsp_out_line_o;
    logic [INVACK_CNT_BITS-1:0]  rsp_out_invack_cnt_i, rsp_out_invack_cnt_o;
    logic [REQ_ID_BITS-1:0]      rsp_out_req_id_i, rsp_out_req_id_o;
    logic [DEST_ID_BITS-1:0]     rsp_out_dest_id_i, rsp_out_dest_id_o;
    logic [WORD_OFFSET_BITS-1:0] rsp_out_word_offset_i, rsp_out_word_offset_o;

    // Reference model state
    logic [REQ_IN_BITS-1:0]  req_q[$];
    logic [RSP_IN_BITS-1:0]  rsp_q[$];
    logic [RSP_OUT_BITS-1:0] out_q[$];
    logic [REQ_IN_BITS-1:0]  exp_req_cap, exp_req_stall;
    logic [RSP_IN_BITS-1:0]  exp_rsp_cap;
    logic [31:0]             lcg_state;
    logic                    req_moved, rsp_moved, out_moved;
    int                      req_sent, req_got, rsp_sent, rsp_got, out_sent, out_got, cycle;

    tb_clk_gen clk_gen_i (
        .clk_o(clk),
        .rst_o(rst)
    );

    llc_channels llc_channels_i (.*);

    bind llc_channels llc_channels_asserts asserts_i (.*);

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic coin();
        logic [31:0] r;
        r = next_rand();
        return r[31];
    endfunction

    function automatic logic [127:0] rand_bits();
        return {next_rand(), next_rand(), next_rand(), next_rand()};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic expect_true(input logic ok, input string what);
        assert (ok) else stop_run($sformatf("Error at time %0t: %s", $time, what));
    endtask

    // Captured words must match the model every cycle
    task automatic check_outputs();
        logic [REQ_IN_BITS-1:0]    req_seen;
        logic [RSP_IN_BITS-1:0]    rsp_seen;
        logic [LINE_ADDR_BITS-1:0] stall_addr;
        req_seen = {req_in_coh_msg_o, req_in_hprot_o, req_in_addr_o, req_in_line_o,
                    req_in_req_id_o, req_in_word_offset_o, req_in_valid_words_o};
        rsp_seen = {rsp_in_coh_msg_o, rsp_in_addr_o, rsp_in_line_o, rsp_in_req_id_o};
        // Address sits right below coh_msg and hprot in the packed request
        stall_addr = exp_req_stall[REQ_IN_BITS-COH_MSG_BITS-HPROT_BITS-1 -: LINE_ADDR_BITS];
        expect_true(req_seen == exp_req_cap,
                    $sformatf("request fields %h, expected %h", req_seen, exp_req_cap));
        expect_true(req_in_stalled_addr_o == stall_addr,
                    $sformatf("stalled address %h, expected %h",
                              req_in_stalled_addr_o, stall_addr));
        expect_true(rsp_seen == exp_rsp_cap,
                    $sformatf("response fields %h, expected %h", rsp_seen, exp_rsp_cap));
        if (llc_channels_i.asserts_i.fail_count != 0) begin
            stop_run("A protocol assertion in the bound checker failed");
        end
    endtask

    // New words only after the previous one moved
    task automatic drive_inputs();
        logic [127:0] r;
        if (req_moved || !req_in_valid_i) begin
            r = rand_bits();
            req_in_valid_i = (req_sent < WORDS) && coin();
            {req_in_coh_msg_i, req_in_hprot_i, req_in_addr_i, req_in_line_i, req_in_req_id_i,
             req_in_word_offset_i, req_in_valid_words_i} = r[REQ_IN_BITS-1:0];
        end
        if (rsp_moved || !rsp_in_valid_i) begin
            r = rand_bits();
            rsp_in_valid_i = (rsp_sent < WORDS) && coin();
            {rsp_in_coh_msg_i, rsp_in_addr_i, rsp_in_line_i, rsp_in_req_id_i} =
                r[RSP_IN_BITS-1:0];
        end
        if (out_moved || !rsp_out_valid_int_i) begin
            r = rand_bits();
            rsp_out_valid_int_i = (out_sent < WORDS) && coin();
            {rsp_out_coh_msg_i, rsp_out_addr_i, rsp_out_line_i, rsp_out_invack_cnt_i,
             rsp_out_req_id_i, rsp_out_dest_id_i, rsp_out_word_offset_i} = r[RSP_OUT_BITS-1:0];
        end
        set_req_in_stalled_i = (cycle % 40 == 10);
        update_req_in_from_stalled_i = (cycle % 40 == 30);
        req_in_ready_int_i = coin() && !update_req_in_from_stalled_i;
        rsp_in_ready_int_i = coin();
        rsp_out_ready_i = coin();
    endtask

    // Runs after the falling-edge drive, once the inputs have settled
    task automatic sample_handshakes();
        logic [RSP_OUT_BITS-1:0] out_seen;
        req_moved = req_in_valid_i && req_in_ready_o;
        rsp_moved = rsp_in_valid_i && rsp_in_ready_o;
        out_moved = rsp_out_valid_int_i && rsp_out_ready_int_o;
        if (req_moved) begin
            req_q.push_back({req_in_coh_msg_i, req_in_hprot_i, req_in_addr_i, req_in_line_i,
                             req_in_req_id_i, req_in_word_offset_i, req_in_valid_words_i});
            req_sent++;
        end
        if (rsp_moved) begin
            rsp_q.push_back({rsp_in_coh_msg_i, rsp_in_addr_i, rsp_in_line_i, rsp_in_req_id_i});
            rsp_sent++;
        end
        if (out_moved) begin
            out_q.push_back({rsp_out_coh_msg_i, rsp_out_addr_i, rsp_out_line_i,
                             rsp_out_invack_cnt_i, rsp_out_req_id_i, rsp_out_dest_id_i,
                             rsp_out_word_offset_i});
            out_sent++;
        end
        if (set_req_in_stalled_i) begin
            exp_req_stall = exp_req_cap;
        end
        if (update_req_in_from_stalled_i) begin
            exp_req_cap = exp_req_stall;
        end else if (req_in_valid_int_o && req_in_ready_int_i) begin
            expect_true(req_q.size() > 0, "request reached the controller before it was sent");
            exp_req_cap = req_q.pop_front();
            req_got++;
        end
        if (rsp_in_valid_int_o && rsp_in_ready_int_i) begin
            expect_true(rsp_q.size() > 0, "response reached the controller before it was sent");
            exp_rsp_cap = rsp_q.pop_front();
            rsp_got++;
        end
        if (rsp_out_valid_o && rsp_out_ready_i) begin
            out_seen = {rsp_out_coh_msg_o, rsp_out_addr_o, rsp_out_line_o, rsp_out_invack_cnt_o,
                        rsp_out_req_id_o, rsp_out_dest_id_o, rsp_out_word_offset_o};
            expect_true(out_q.size() > 0, "response output left before the controller sent it");
            expect_true(out_seen == out_q[0],
                        $sformatf("response output %h, expected %h", out_seen, out_q[0]));
            void'(out_q.pop_front());
            out_got++;
        end
    endtask

    initial begin
        lcg_state = 32'hc567;
        {req_in_valid_i, req_in_ready_int_i, rsp_in_valid_i, rsp_in_ready_int_i} = '0;
        {rsp_out_valid_int_i, rsp_out_ready_i} = '0;
        {set_req_in_stalled_i, update_req_in_from_stalled_i} = '0;
        {req_in_coh_msg_i, req_in_hprot_i, req_in_addr_i, req_in_line_i, req_in_req_id_i,
         req_in_word_offset_i, req_in_valid_words_i} = '0;
        {rsp_in_coh_msg_i, rsp_in_addr_i, rsp_in_line_i, rsp_in_req_id_i} = '0;
        {rsp_out_coh_msg_i, rsp_out_addr_i, rsp_out_line_i, rsp_out_invack_cnt_i,
         rsp_out_req_id_i, rsp_out_dest_id_i, rsp_out_word_offset_i} = '0;
        {exp_req_cap, exp_req_stall, exp_rsp_cap} = '0;
        {req_moved, rsp_moved, out_moved} = '0;
        {req_sent, req_got, rsp_sent, rsp_got, out_sent, out_got, cycle} = '0;
        wait (rst);
        while (req_got < WORDS || rsp_got < WORDS || out_got < WORDS) begin
            @(negedge clk);
            cycle++;
            if (cycle > MAX_CYCLES) begin
                stop_run("Timeout: traffic did not finish within the cycle limit");
            end
            check_outputs();
            drive_inputs();
            #1;
            sample_handshakes();
        end
        // Last capture lands on the next edge
        @(negedge clk);
        check_outputs();
        if (llc_channels_i.asserts_i.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            stop_run("A protocol assertion in the bound checker failed");
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/llc_pkg.sv
rtl/llc_bypass_buffer.sv
rtl/llc_input_channel.sv
rtl/llc_req_in_channel.sv
rtl/llc_channels.sv
tb/tb_clk_gen.sv
tb/llc_channels_asserts.sv
tb/llc_channels_tb.sv

// ==== Makefile ====
TOP = llc_channels_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
